/* hw/axi_pkg.sv */
`default_nettype none

package axi_pkg;

    // ARBURST encoding, 2'b11 is reserved
    typedef enum logic [1:0] {
        fixed = 2'b00,
        incr  = 2'b01,
        wrap  = 2'b10
    } axi_burst_t;

    // RRESP encoding
    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } axi_resp_t;

endpackage

`default_nettype wire

/* hw/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// front-end and memory widths
`define ADDR_W      16
`define DATA_W      32
`define NBYTES_W    2   // byte offset inside a word

// line geometry: 4 words per line, 16 lines
`define OFFSET_W    2   // word-in-line bits, also sets the burst length
`define INDEX_W     4
`define TAG_W       8   // ADDR_W - INDEX_W - OFFSET_W - NBYTES_W

// AXI read id, fixed since only one burst is ever in flight
`define AXI_ID      0
`define AXI_ID_W    1

`endif

/* hw/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             req,
    input  wire  [`ADDR_W-1:0]              addr,
    output logic                            ready,
    output logic                            resp_valid,
    output logic [`INDEX_W-1:0]             lookup_index,
    output logic [`TAG_W-1:0]               lookup_tag,
    input  wire                             hit,
    output logic [`INDEX_W-1:0]             rd_index,
    output logic [`OFFSET_W-1:0]            rd_offset,
    output logic                            replace_valid,
    output logic [`TAG_W+`INDEX_W-1:0]      replace_addr,
    input  wire                             replace
);

    ctrl_state_t state;
    logic        lat_valid;                         // a request is waiting for its answer
    logic [`ADDR_W-1:`NBYTES_W] lat_addr;           // word address of that request
    logic        miss;

    // address fields of the latched request
    assign lookup_tag   = lat_addr[`ADDR_W-1 -: `TAG_W];
    assign lookup_index = lat_addr[`NBYTES_W+`OFFSET_W +: `INDEX_W];
    assign replace_addr = lat_addr[`ADDR_W-1 -: `TAG_W+`INDEX_W];

    // the data read starts on the request edge itself or rereads after a refill
    always_comb begin
        if (state == miss_wait) begin
            rd_index  = lookup_index;
            rd_offset = lat_addr[`NBYTES_W +: `OFFSET_W];
        end else begin
            rd_index  = addr[`NBYTES_W+`OFFSET_W +: `INDEX_W];
            rd_offset = addr[`NBYTES_W +: `OFFSET_W];
        end
    end

    assign miss          = (state == lookup) && lat_valid && !hit;
    assign replace_valid = miss;   // single cycle since the FSM leaves lookup on the next edge

    assign ready      = ((state == lookup) && !miss) || (state == refill_read);
    assign resp_valid = ((state == lookup) && lat_valid && hit) || (state == refill_read);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= lookup;
            lat_valid <= 1'b0;
        end else begin
            case (state)
                lookup: begin
                    if (miss)
                        state <= miss_wait;     // keep the request latched
                    else
                        lat_valid <= req;
                end
                miss_wait: begin
                    // replace is already high on the first cycle here
                    if (!replace)
                        state <= refill_read;
                end
                refill_read: begin
                    state     <= lookup;
                    lat_valid <= req;
                end
                default: state <= lookup;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req && ready)
            lat_addr <= addr[`ADDR_W-1:`NBYTES_W];
    end

    // the strobe has no back-pressure so ready has to be respected
    assert property (@(posedge clk) disable iff (reset)
        req |-> ready)
        else $error("request strobed while ready is low");

    // a miss answers only after the refill is done
    assert property (@(posedge clk) disable iff (reset)
        replace |-> !resp_valid)
        else $error("response raised while waiting for a refill");

endmodule

`default_nettype wire

/* hw/cache_data_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_data_store (
    input  wire                     clk,
    input  wire                     word_we,
    input  wire  [`INDEX_W-1:0]     wr_index,
    input  wire  [`OFFSET_W-1:0]    wr_offset,
    input  wire  [`DATA_W-1:0]      wdata,
    input  wire  [`INDEX_W-1:0]     rd_index,
    input  wire  [`OFFSET_W-1:0]    rd_offset,
    output logic [`DATA_W-1:0]      rdata
);

    localparam int DEPTH = 1 << (`INDEX_W + `OFFSET_W);  // 64 words

    logic [`DATA_W-1:0] mem [DEPTH];

    // one word per refill beat
    always_ff @(posedge clk) begin
        if (word_we)
            mem[{wr_index, wr_offset}] <= wdata;
    end

    // registered read, one cycle of latency
    always_ff @(posedge clk) begin
        rdata <= mem[{rd_index, rd_offset}];
    end

endmodule

`default_nettype wire

/* hw/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // front-end controller
    typedef enum logic [1:0] {
        lookup,
        miss_wait,      // refill engine busy
        refill_read     // one cycle to read the freshly filled word
    } ctrl_state_t;

    // AXI line refill engine
    typedef enum logic [1:0] {
        idle,
        init_process,   // address phase
        load_process,   // data beats
        end_process     // settle cycle, retry on error
    } refill_state_t;

endpackage

`default_nettype wire

/* hw/cache_refill_axi.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_refill_axi
    import cache_pkg::*;
    import axi_pkg::*;
(
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             replace_valid,
    input  wire  [`TAG_W+`INDEX_W-1:0]      replace_addr,   // tag and index of the line
    output logic                            replace,
    output logic                            line_done,
    output logic                            read_valid,
    output logic [`OFFSET_W-1:0]            read_addr,
    output logic [`DATA_W-1:0]              read_rdata,
    output logic                            arvalid,
    output logic [`ADDR_W-1:0]              araddr,
    output logic [7:0]                      arlen,
    output logic [2:0]                      arsize,
    output axi_burst_t                      arburst,
    output logic [`AXI_ID_W-1:0]            arid,
    input  wire                             arready,
    input  wire                             rvalid,
    input  wire  [`DATA_W-1:0]              rdata,
    input  wire  axi_resp_t                 rresp,
    input  wire                             rlast,
    output logic                            rready
);

    refill_state_t state;
    logic          slave_error;  // sticky over the burst, a burst cannot be cut short

    // burst fields never change, one whole line per burst
    assign arid    = `AXI_ID_W'(`AXI_ID);
    assign arlen   = 8'((1 << `OFFSET_W) - 1);      // 4 beats
    assign arsize  = 3'(`NBYTES_W);                 // full-width beats
    assign arburst = incr;
    assign araddr  = {replace_addr, {(`OFFSET_W + `NBYTES_W){1'b0}}};

    // beats go straight into the data store
    assign read_rdata = rdata;
    assign read_valid = rvalid && rready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= idle;
            read_addr   <= '0;
            slave_error <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    read_addr   <= '0;
                    slave_error <= 1'b0;
                    if (replace_valid)
                        state <= init_process;
                end
                init_process: begin
                    // also the restart point after a failed burst
                    read_addr   <= '0;
                    slave_error <= 1'b0;
                    if (arready)
                        state <= load_process;
                end
                load_process: begin
                    if (rvalid) begin
                        if (rresp != okay)
                            slave_error <= 1'b1;   // finish the burst, then retry
                        if (rlast)
                            state <= end_process;  // offset stays on the last word
                        else
                            read_addr <= read_addr + 1'b1;
                    end
                end
                default: begin
                    // end_process covers the data store write of the last beat
                    if (slave_error)
                        state <= init_process;
                    else
                        state <= idle;
                end
            endcase
        end
    end

    assign replace   = (state != idle);
    assign arvalid   = (state == init_process);
    assign rready    = (state == load_process);
    assign line_done = (state == end_process) && !slave_error;  // tag is written only on a clean burst

    // the slave may only close a burst that was actually issued
    assert property (@(posedge clk) disable iff (reset)
        (rvalid && rlast) |-> (state == load_process))
        else $error("rlast beat seen outside of a refill burst");

    // the controller must wait for the running refill to finish
    assert property (@(posedge clk) disable iff (reset)
        replace_valid |-> !replace)
        else $error("refill requested while a refill is still running");

endmodule

`default_nettype wire

/* hw/cache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_tag_store (
    input  wire                     clk,
    input  wire                     reset,
    input  wire  [`INDEX_W-1:0]     lookup_index,
    input  wire  [`TAG_W-1:0]       lookup_tag,
    output logic                    hit,
    input  wire  [`INDEX_W-1:0]     fill_index,
    input  wire  [`TAG_W-1:0]       fill_tag,
    input  wire                     line_done
);

    localparam int NLINES = 1 << `INDEX_W;

    logic [`TAG_W-1:0] tags [NLINES];
    logic [NLINES-1:0] valid;

    // reset invalidates the whole cache at once
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            valid <= '0;
        else if (line_done)
            valid[fill_index] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (line_done)
            tags[fill_index] <= fill_tag;
    end

    // combinational compare, ready in the same cycle as the latched address
    assign hit = valid[lookup_index] && (tags[lookup_index] == lookup_tag);

endmodule

`default_nettype wire

/* hw/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_top
    import axi_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset,

    // requester side
    input  wire                         req,
    input  wire  [`ADDR_W-1:0]          addr,
    output wire                         ready,
    output wire                         resp_valid,
    output wire  [`DATA_W-1:0]          rdata,

    // AXI read address channel
    output wire                         arvalid,
    input  wire                         arready,
    output wire  [`ADDR_W-1:0]          araddr,
    output wire  [7:0]                  arlen,
    output wire  [2:0]                  arsize,
    output wire  axi_burst_t            arburst,
    output wire  [`AXI_ID_W-1:0]        arid,

    // AXI read data channel, data renamed to keep it apart from the front-end rdata
    input  wire                         rvalid,
    output wire                         rready,
    input  wire  [`DATA_W-1:0]          axi_rdata,
    input  wire  axi_resp_t             rresp,
    input  wire                         rlast
);

    wire [`INDEX_W-1:0]          lookup_index;
    wire [`TAG_W-1:0]            lookup_tag;
    wire                         hit;
    wire [`INDEX_W-1:0]          rd_index;
    wire [`OFFSET_W-1:0]         rd_offset;
    wire                         replace_valid;
    wire [`TAG_W+`INDEX_W-1:0]   replace_addr;
    wire                         replace;
    wire                         line_done;
    wire                         read_valid;
    wire [`OFFSET_W-1:0]         read_addr;
    wire [`DATA_W-1:0]           read_rdata;
    wire [`INDEX_W-1:0]          fill_index;
    wire [`TAG_W-1:0]            fill_tag;

    // the line being refilled, held by the controller for the whole miss
    assign fill_index = replace_addr[`INDEX_W-1:0];
    assign fill_tag   = replace_addr[`TAG_W+`INDEX_W-1:`INDEX_W];

    cache_ctrl u_cache_ctrl (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .addr          (addr),
        .ready         (ready),
        .resp_valid    (resp_valid),
        .lookup_index  (lookup_index),
        .lookup_tag    (lookup_tag),
        .hit           (hit),
        .rd_index      (rd_index),
        .rd_offset     (rd_offset),
        .replace_valid (replace_valid),
        .replace_addr  (replace_addr),
        .replace       (replace)
    );

    cache_tag_store u_cache_tag_store (
        .clk          (clk),
        .reset        (reset),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .line_done    (line_done)
    );

    cache_data_store u_cache_data_store (
        .clk       (clk),
        .word_we   (read_valid),
        .wr_index  (fill_index),
        .wr_offset (read_addr),
        .wdata     (read_rdata),
        .rd_index  (rd_index),
        .rd_offset (rd_offset),
        .rdata     (rdata)
    );

    cache_refill_axi u_cache_refill_axi (
        .clk           (clk),
        .reset         (reset),
        .replace_valid (replace_valid),
        .replace_addr  (replace_addr),
        .replace       (replace),
        .line_done     (line_done),
        .read_valid    (read_valid),
        .read_addr     (read_addr),
        .read_rdata    (read_rdata),
        .arvalid       (arvalid),
        .araddr        (araddr),
        .arlen         (arlen),
        .arsize        (arsize),
        .arburst       (arburst),
        .arid          (arid),
        .arready       (arready),
        .rvalid        (rvalid),
        .rdata         (axi_rdata),
        .rresp         (rresp),
        .rlast         (rlast),
        .rready        (rready)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --top-module tb_cache -f sim.f -o tb_cache_sim; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/tb_cache_sim)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "PASS: all tests" <<< "$output"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi

/* sim.f */
+incdir+hw
hw/cache_pkg.sv
hw/axi_pkg.sv
hw/cache_refill_axi.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/cache_ctrl.sv
hw/cache_top.sv
tb/axi_mem_model.sv
tb/tb_cache.sv

/* tb/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module axi_mem_model
    import axi_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 arvalid,
    output logic                arready,
    input  wire  [`ADDR_W-1:0]  araddr,
    input  wire  [7:0]          arlen,
    input  wire  [2:0]          arsize,
    input  wire  axi_burst_t    arburst,
    input  wire  [`AXI_ID_W-1:0] arid,
    output logic                rvalid,
    input  wire                 rready,
    output logic [`DATA_W-1:0]  rdata,
    output axi_resp_t           rresp,
    output logic                rlast,
    output logic                fault,      // a malformed burst request was seen
    output int                  ar_count    // address handshakes so far
);

    localparam logic [`ADDR_W-1:0] ERR_LINE = 16'h0140;

    logic [15:0]        lfsr_state;
    logic [15:0]        rnd;
    logic [1:0]         ar_wait;            // cycles to hold arready low
    logic               busy;               // data phase of a burst running
    logic [`ADDR_W-1:0] base;
    logic [1:0]         beat;
    logic               inject;             // slverr on beat 1 of this burst
    logic               err_done;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    // upper half is the byte address and lower half its inverse
    function automatic logic [`DATA_W-1:0] word_at(input logic [`ADDR_W-1:0] a);
        return {a, ~a};
    endfunction

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr_state = 16'd72;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rlast    <= 1'b0;
            rresp    <= okay;
            rdata    <= '0;
            busy     <= 1'b0;
            base     <= '0;
            beat     <= '0;
            inject   <= 1'b0;
            err_done <= 1'b0;
            fault    <= 1'b0;
            ar_count <= 0;
            ar_wait  <= '0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                arready  <= 1'b0;
                busy     <= 1'b1;
                base     <= araddr;
                beat     <= '0;
                ar_count <= ar_count + 1;
                if (arlen != 8'd3 || arburst != incr || arsize != 3'd2
                        || arid != `AXI_ID_W'(`AXI_ID)
                        || araddr[`OFFSET_W+`NBYTES_W-1:0] != '0) begin
                    $display("bad AXI read request: addr %h len %0d size %0d burst %0d id %0d",
                             araddr, arlen, arsize, arburst, arid);
                    fault <= 1'b1;
                end
                inject <= (araddr == ERR_LINE) && !err_done;  // first burst to that line only
                if (araddr == ERR_LINE)
                    err_done <= 1'b1;
                take_bits(2, rnd);
                ar_wait <= rnd[1:0];    // stall for the next request
            end else if (arvalid) begin
                if (ar_wait == 2'd0)
                    arready <= 1'b1;
                else
                    ar_wait <= ar_wait - 2'd1;
            end
        end else begin
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
                rresp  <= okay;
                if (beat == 2'd3)
                    busy <= 1'b0;
                else
                    beat <= beat + 2'd1;
            end else if (!rvalid) begin
                take_bits(1, rnd);
                if (rnd[0]) begin   // otherwise a gap cycle
                    rvalid <= 1'b1;
                    rdata  <= word_at({base[`ADDR_W-1:4], beat, 2'b00});
                    rlast  <= (beat == 2'd3);
                    rresp  <= (inject && beat == 2'd1) ? slverr : okay;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tb_cache
    import axi_pkg::*;
();

    localparam int NRANDOM = 24;
    localparam logic [15:0] ERR_LINE = 16'h0140;

    logic                clk;
    logic                reset;
    logic                req;
    logic [`ADDR_W-1:0]  addr;
    logic                ready;
    logic                resp_valid;
    logic [`DATA_W-1:0]  rdata;
    logic                arvalid;
    logic                arready;
    logic [`ADDR_W-1:0]  araddr;
    logic [7:0]          arlen;
    logic [2:0]          arsize;
    axi_burst_t          arburst;
    logic [`AXI_ID_W-1:0] arid;
    logic                rvalid;
    logic                rready;
    logic [`DATA_W-1:0]  axi_rdata;
    axi_resp_t           rresp;
    logic                rlast;
    logic                model_fault;
    int                  ar_count;

    logic [15:0] row_addr [64];    // stimulus table
    logic        row_hit  [64];    // expected hit for each row
    int          nrows;
    logic        ref_valid [16];   // expected cache contents while building the table
    logic [7:0]  ref_tag   [16];
    logic [15:0] lfsr_state;
    int          cycles;
    int          limit;
    int          resp_count;

    cache_top u_cache_top (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .addr       (addr),
        .ready      (ready),
        .resp_valid (resp_valid),
        .rdata      (rdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .arburst    (arburst),
        .arid       (arid),
        .rvalid     (rvalid),
        .rready     (rready),
        .axi_rdata  (axi_rdata),
        .rresp      (rresp),
        .rlast      (rlast)
    );

    axi_mem_model u_axi_mem_model (
        .clk      (clk),
        .reset    (reset),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .arlen    (arlen),
        .arsize   (arsize),
        .arburst  (arburst),
        .arid     (arid),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (axi_rdata),
        .rresp    (rresp),
        .rlast    (rlast),
        .fault    (model_fault),
        .ar_count (ar_count)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    // memory word at the aligned byte address
    function automatic logic [31:0] word_of(input logic [15:0] a);
        logic [15:0] w;
        w = {a[15:2], 2'b00};
        return {w, ~w};
    endfunction

    task stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic add_row(input logic [15:0] a, input logic h);
        row_addr[nrows] = a;
        row_hit[nrows]  = h;
        nrows++;
        ref_valid[a[7:4]] = 1'b1;
        ref_tag[a[7:4]]   = a[15:8];
    endtask

    task automatic build_table();
        int i;
        logic [15:0] bits;
        logic [15:0] a;
        logic [15:0] prev;
        nrows = 0;
        for (i = 0; i < 16; i++)
            ref_valid[i] = 1'b0;
        add_row(16'h0238, 1'b0);    // cold miss followed by the rest of the line
        add_row(16'h0230, 1'b1);
        add_row(16'h0234, 1'b1);
        add_row(16'h023C, 1'b1);
        add_row(16'h0238, 1'b1);
        add_row(16'h0144, 1'b0);    // slverr line needs two bursts
        add_row(16'h0140, 1'b1);
        add_row(16'h014C, 1'b1);
        add_row(16'h0330, 1'b0);    // same index as 0x023x
        add_row(16'h0234, 1'b0);
        add_row(16'h0238, 1'b1);
        add_row(16'h0334, 1'b0);
        add_row(16'h0330, 1'b1);
        add_row(16'h2140, 1'b0);
        add_row(16'h0148, 1'b0);    // error line again with a single burst
        add_row(16'h0140, 1'b1);
        add_row(16'h0000, 1'b0);
        add_row(16'h000C, 1'b1);
        add_row(16'hFFF0, 1'b0);
        add_row(16'hFFFC, 1'b1);
        prev = '0;
        for (i = 0; i < NRANDOM; i++) begin
            take_bits(1, bits);
            if (bits[0] && i > 0) begin
                take_bits(2, bits);
                a = {prev[15:4], bits[1:0], 2'b00};    // another word of the last line
            end else begin
                take_bits(10, bits);
                a = {6'b0, bits[9:0]};    // 4 tags with any index and byte offset
            end
            add_row(a, ref_valid[a[7:4]] && (ref_tag[a[7:4]] == a[15:8]));
            prev = a;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!reset && resp_valid)
            resp_count <= resp_count + 1;
        if (model_fault) begin
            $display("memory model saw an illegal AXI read request");
            stop_on_error();
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the run hung after %0d cycles", cycles);
            stop_on_error();
        end
    end

    initial begin
        int r;
        int latency;
        int bursts;
        int ar_before;
        logic err_seen;
        reset      = 1'b1;
        req        = 1'b0;
        addr       = '0;
        cycles     = 0;
        resp_count = 0;
        limit      = 0;
        err_seen   = 1'b0;
        lfsr_state = 16'd72;
        build_table();
        limit = nrows * 60;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (r = 0; r < nrows; r++) begin
            @(negedge clk);
            while (!ready)
                @(negedge clk);
            ar_before = ar_count;
            @(posedge clk);
            check_value("resp_count", resp_count, r);    // no stray responses so far
            req  <= 1'b1;
            addr <= row_addr[r];
            @(posedge clk);    // accepted on this edge
            req <= 1'b0;
            latency = 0;
            do begin
                @(negedge clk);
                latency++;
            end while (!resp_valid);
            check_value("rdata", rdata, word_of(row_addr[r]));
            if (row_hit[r]) begin
                check_value("hit_latency", latency, 1);
                bursts = 0;
            end else begin
                check_value("miss_latency_over_1", 32'(latency > 1), 1);
                bursts = 1;
                if ({row_addr[r][15:4], 4'h0} == ERR_LINE && !err_seen) begin
                    bursts   = 2;    // retried after slverr
                    err_seen = 1'b1;
                end
            end
            check_value("ar_handshakes", ar_count - ar_before, bursts);
        end
        repeat (4) @(posedge clk);
        check_value("resp_count", resp_count, nrows);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire
